//--- run.sh
#!/bin/sh
# Build and run the paging unit testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert --top-module zx_paging_tb -f verilog.f -o zx_paging_sim \
	&& ./obj_dir/zx_paging_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "All tests passed!" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }

//--- tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
	parameter int PERIOD = 8
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

endmodule

//--- verilog.f
zx_paging_pkg.sv
zx_port_decode.sv
zx_page_regs.sv
zx_addr_map.sv
zx_paging.sv
tb_clock.sv
zx_paging_assertions.sv
zx_paging_tb.sv

//--- zx_addr_map.sv
`timescale 1ns/1ns

module zx_addr_map (
	input  zx_paging_pkg::cpu_addr_t   addr,
	input  logic                       mreq_rd,
	input  logic                       mreq_wr,
	input  zx_paging_pkg::cpu_data_t   page_reg,
	input  zx_paging_pkg::plus3_cfg_u  plus3_cfg,
	input  logic [2:0]                 page_ext,
	input  logic                       is_48,
	input  logic                       is_plus3,
	output zx_paging_pkg::flat_addr_t  mem_addr,
	output logic                       mem_rd,
	output logic                       mem_we,
	output logic                       screen_page,
	output logic                       motor
);

	logic [1:0]                           quarter;
	logic [zx_paging_pkg::PAGE_BITS-1:0]  offset;
	logic                                 special;
	logic                                 cfg_b1;
	logic                                 cfg_b0;
	logic                                 rom_sel;
	zx_paging_pkg::ram_page_t             ram_page;
	zx_paging_pkg::rom_page_t             rom_page;

	assign quarter = addr[15:zx_paging_pkg::PAGE_BITS];
	assign offset  = addr[zx_paging_pkg::PAGE_BITS-1:0];

	assign special = plus3_cfg.spec.special;
	assign cfg_b1  = plus3_cfg.spec.ram_cfg[1];
	assign cfg_b0  = plus3_cfg.spec.ram_cfg[0];

	// ==========================================================
	// ROM page select
	// ==========================================================

	// +3 has four ROMs, the rest pick from the 128K pair or 48K ROM
	assign rom_page = is_plus3
		? {2'b10, plus3_cfg.norm.rom_hi, page_reg[4]}
		: {is_48, 2'b11, is_48 | page_reg[4]};

	// ==========================================================
	// Quarter mapping
	// ==========================================================

	always_comb begin
		rom_sel  = 1'b0;
		ram_page = '0;
		if (special) begin
			// All-RAM configurations of the +3
			case (quarter)
				2'd0: ram_page = {3'b000, cfg_b1 | cfg_b0, 2'b00};
				2'd1: ram_page = {3'b000, cfg_b1 | cfg_b0, cfg_b1 & cfg_b0, 1'b1};
				2'd2: ram_page = {3'b000, cfg_b1 | cfg_b0, 2'b10};
				default: ram_page = {3'b000, cfg_b0 & ~cfg_b1, 2'b11};
			endcase
		end else begin
			case (quarter)
				2'd0: rom_sel = 1'b1;
				2'd1: ram_page = 6'd5;
				2'd2: ram_page = 6'd2;
				// Banked top quarter
				default: ram_page = {page_ext, page_reg[2:0]};
			endcase
		end
	end

	assign mem_addr = rom_sel
		? {zx_paging_pkg::ROM_SPACE, rom_page, offset}
		: {1'b0, ram_page, offset};

	// ROM is write protected
	assign mem_rd = mreq_rd;
	assign mem_we = mreq_wr & (special | addr[15] | addr[14]);

	assign screen_page = page_reg[3];
	assign motor       = plus3_cfg.norm.motor;

endmodule

//--- zx_page_regs.sv
`timescale 1ns/1ns

module zx_page_regs (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  zx_paging_pkg::cpu_data_t  data,
	input  logic                      wr_7ffd,
	input  logic                      wr_1ffd,
	input  logic                      wr_eff7,
	input  logic                      is_48,
	input  logic                      is_p1024,
	output zx_paging_pkg::cpu_data_t  page_reg,
	output zx_paging_pkg::plus3_cfg_u plus3_cfg,
	output logic [2:0]                page_ext,
	output logic                      paging_locked
);

	// Pentagon control, bit 2 drops back to 128K behaviour
	zx_paging_pkg::cpu_data_t eff7_reg;

	logic page_ok;
	logic ext_ok;

	// ==========================================================
	// Paging lock
	// ==========================================================

	// 48K never pages
	// 128K and +3 lock on 7FFD bit 5 until reset
	// Pentagon only locks once EFF7 bit 2 is set
	assign paging_locked = is_48
		| (~is_p1024 & page_reg[5])
		| (is_p1024 & eff7_reg[2] & page_reg[5]);

	assign page_ok = ~paging_locked;

	// Extension bits follow 7FFD only in full 1024K mode
	assign ext_ok = is_p1024 & ~eff7_reg[2];

	// ==========================================================
	// Register file
	// ==========================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			page_reg  <= '0;
			plus3_cfg <= '0;
			eff7_reg  <= '0;
			page_ext  <= 3'd0;
		end else begin
			if (wr_7ffd && page_ok) begin
				page_reg <= data;
				// Page bits 5..3 come from D5, D7, D6
				if (ext_ok) begin
					page_ext <= {data[5], data[7:6]};
				end
			end

			if (wr_1ffd && page_ok) begin
				plus3_cfg <= zx_paging_pkg::plus3_cfg_u'(data);
			end

			// EFF7 ignores the lock
			if (wr_eff7) begin
				eff7_reg <= data;
			end
		end
	end

endmodule

//--- zx_paging.sv
`timescale 1ns/1ns

module zx_paging (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  zx_paging_pkg::machine_t   machine,
	input  zx_paging_pkg::cpu_addr_t  addr,
	input  zx_paging_pkg::cpu_data_t  data,
	input  logic                      io_wr,
	input  logic                      mreq_rd,
	input  logic                      mreq_wr,
	output zx_paging_pkg::flat_addr_t mem_addr,
	output logic                      mem_rd,
	output logic                      mem_we,
	output logic                      screen_page,
	output logic                      motor,
	output logic                      paging_locked
);

	logic                      wr_7ffd;
	logic                      wr_1ffd;
	logic                      wr_eff7;
	logic                      is_48;
	logic                      is_plus3;
	logic                      is_p1024;
	zx_paging_pkg::cpu_data_t  page_reg;
	zx_paging_pkg::plus3_cfg_u plus3_cfg;
	logic [2:0]                page_ext;

	// Port writes and machine type
	zx_port_decode u_decode (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.machine  (machine),
		.addr     (addr),
		.io_wr    (io_wr),
		.wr_7ffd  (wr_7ffd),
		.wr_1ffd  (wr_1ffd),
		.wr_eff7  (wr_eff7),
		.is_48    (is_48),
		.is_plus3 (is_plus3),
		.is_p1024 (is_p1024)
	);

	// Paging state
	zx_page_regs u_regs (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.data          (data),
		.wr_7ffd       (wr_7ffd),
		.wr_1ffd       (wr_1ffd),
		.wr_eff7       (wr_eff7),
		.is_48         (is_48),
		.is_p1024      (is_p1024),
		.page_reg      (page_reg),
		.plus3_cfg     (plus3_cfg),
		.page_ext      (page_ext),
		.paging_locked (paging_locked)
	);

	// CPU address to flat memory address
	zx_addr_map u_map (
		.addr        (addr),
		.mreq_rd     (mreq_rd),
		.mreq_wr     (mreq_wr),
		.page_reg    (page_reg),
		.plus3_cfg   (plus3_cfg),
		.page_ext    (page_ext),
		.is_48       (is_48),
		.is_plus3    (is_plus3),
		.mem_addr    (mem_addr),
		.mem_rd      (mem_rd),
		.mem_we      (mem_we),
		.screen_page (screen_page),
		.motor       (motor)
	);

endmodule

//--- zx_paging_assertions.sv
`timescale 1ns/1ns

module zx_paging_assertions (
	input logic        clk_sys,
	input logic        reset,
	input logic [15:0] addr,
	input logic        mem_we,
	input logic        paging_locked,
	input logic        wr_7ffd,
	input logic        wr_1ffd,
	input logic        wr_eff7,
	input logic [7:0]  page_reg,
	input logic [7:0]  plus3_cfg,
	input logic [2:0]  page_ext
);

	// Failed assertions, read back by the testbench
	int failures = 0;

	// ==========================================================
	// ROM write protection
	// ==========================================================

	assert property (@(posedge clk_sys) disable iff (reset)
		!(mem_we && addr[15:14] == 2'b00 && !plus3_cfg[0]))
	else begin
		$error("mem_we high for a quarter 0 address outside all-RAM mode");
		failures++;
	end

	// ==========================================================
	// Write strobes are single cycle
	// ==========================================================

	assert property (@(posedge clk_sys) disable iff (reset)
		(wr_7ffd || wr_1ffd || wr_eff7) |=> !(wr_7ffd || wr_1ffd || wr_eff7))
	else begin
		$error("port write strobe longer than one cycle");
		failures++;
	end

	// Locked registers only move on an EFF7 write
	assert property (@(posedge clk_sys) disable iff (reset)
		(paging_locked && !wr_eff7)
		|=> ($stable(page_reg) && $stable(plus3_cfg) && $stable(page_ext)))
	else begin
		$error("paging register changed while locked");
		failures++;
	end

endmodule

//--- zx_paging_pkg.sv
package zx_paging_pkg;

	// ==========================================================
	// Bus widths
	// ==========================================================

	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  cpu_data_t;

	// Bit 20 marks ROM space, ROM page sits in bits 17..14
	typedef logic [20:0] flat_addr_t;

	// 16 KB RAM pages
	typedef logic [5:0] ram_page_t;
	typedef logic [3:0] rom_page_t;

	// In-page offset width
	localparam int PAGE_BITS = 14;

	// Prefix of ROM addresses in the flat map
	localparam logic [2:0] ROM_SPACE = 3'b101;

	// ==========================================================
	// Machine type codes
	// ==========================================================

	// Unlisted codes behave as 128K
	typedef enum logic [2:0] {
		MACH_ZX128 = 3'd0,
		MACH_P1024 = 3'd1,
		MACH_ZX48  = 3'd3,
		MACH_PLUS3 = 3'd4
	} machine_t;

	// ==========================================================
	// +3 paging register (port 1FFD)
	// ==========================================================

	// Normal mode, ROM high bit selects the ROM pair
	typedef struct packed {
		logic [3:0] unused;
		logic       motor;
		logic       rom_hi;
		logic       unused_b1;
		logic       special;
	} plus3_norm_t;

	// Special mode, all four quarters are RAM
	typedef struct packed {
		logic [3:0] unused;
		logic       motor;
		logic [1:0] ram_cfg;
		logic       special;
	} plus3_spec_t;

	typedef union packed {
		plus3_norm_t norm;
		plus3_spec_t spec;
	} plus3_cfg_u;

endpackage

//--- zx_paging_tb.sv
`timescale 1ns/1ns

module zx_paging_tb;

	localparam int CLK_PERIOD     = 8;
	localparam int MIX_ROUNDS     = 4;
	localparam int MIX_OPS        = 80;
	// A port write takes up to 3 cycles, a quarter sweep 8
	localparam int STEP_CYCLES    = 11;
	localparam int DIRECTED_STEPS = 60;
	localparam int TOTAL_CYCLES   = DIRECTED_STEPS * STEP_CYCLES
		+ MIX_ROUNDS * (MIX_OPS * 3 + STEP_CYCLES + 3);

	logic                      clk_sys;
	logic                      reset;
	zx_paging_pkg::machine_t   machine;
	zx_paging_pkg::cpu_addr_t  addr;
	zx_paging_pkg::cpu_data_t  data;
	logic                      io_wr;
	logic                      mreq_rd;
	logic                      mreq_wr;
	zx_paging_pkg::flat_addr_t mem_addr;
	logic                      mem_rd;
	logic                      mem_we;
	logic                      screen_page;
	logic                      motor;
	logic                      paging_locked;

	// Reference model state
	logic [7:0]  m_7ffd;
	logic [7:0]  m_1ffd;
	logic [7:0]  m_eff7;
	logic [2:0]  m_ext;
	logic        m_is48;
	logic        m_plus3;
	logic        m_p1024;
	logic [31:0] rng_state = 32'd43;
	int          errors = 0;
	int          passed = 0;
	int          failed = 0;

	tb_clock #(.PERIOD(CLK_PERIOD)) u_clock (.clk(clk_sys));

	zx_paging uut (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.machine       (machine),
		.addr          (addr),
		.data          (data),
		.io_wr         (io_wr),
		.mreq_rd       (mreq_rd),
		.mreq_wr       (mreq_wr),
		.mem_addr      (mem_addr),
		.mem_rd        (mem_rd),
		.mem_we        (mem_we),
		.screen_page   (screen_page),
		.motor         (motor),
		.paging_locked (paging_locked)
	);

	bind zx_paging zx_paging_assertions u_assert (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.addr          (addr),
		.mem_we        (mem_we),
		.paging_locked (paging_locked),
		.wr_7ffd       (wr_7ffd),
		.wr_1ffd       (wr_1ffd),
		.wr_eff7       (wr_eff7),
		.page_reg      (page_reg),
		.plus3_cfg     (plus3_cfg),
		.page_ext      (page_ext)
	);

	// ==========================================================
	// Random source and reference model
	// ==========================================================

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function logic [31:0] rand_word();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic logic model_locked();
		return m_is48 | (~m_p1024 & m_7ffd[5]) | (m_p1024 & m_eff7[2] & m_7ffd[5]);
	endfunction

	function automatic logic [20:0] expected_addr(input logic [15:0] a);
		logic       b1;
		logic       b0;
		logic [3:0] rom;
		logic [5:0] page;
		b1 = m_1ffd[2];
		b0 = m_1ffd[1];
		rom = m_plus3 ? {2'b10, m_1ffd[2], m_7ffd[4]} : {m_is48, 2'b11, m_is48 | m_7ffd[4]};
		if (m_1ffd[0]) begin
			case (a[15:14])
				2'd0: page = {3'b000, b1 | b0, 2'b00};
				2'd1: page = {3'b000, b1 | b0, b1 & b0, 1'b1};
				2'd2: page = {3'b000, b1 | b0, 2'b10};
				default: page = {3'b000, b0 & ~b1, 2'b11};
			endcase
		end else if (a[15:14] == 2'd0) begin
			return {3'b101, rom, a[13:0]};
		end else if (a[15:14] == 2'd1) begin
			page = 6'd5;
		end else if (a[15:14] == 2'd2) begin
			page = 6'd2;
		end else begin
			page = {m_ext, m_7ffd[2:0]};
		end
		return {1'b0, page, a[13:0]};
	endfunction

	function automatic logic [15:0] pick_port(input logic [1:0] sel, input logic [15:0] r);
		case (sel)
			2'd0: return 16'h7ffd;
			2'd1: return 16'h1ffd;
			2'd2: return 16'heff7;
			default: return r;
		endcase
	endfunction

	// ==========================================================
	// Checks and bus tasks
	// ==========================================================

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want) begin
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, want);
			errors++;
		end
	endtask

	task automatic check_state();
		check_value("screen_page", 32'(screen_page), 32'(m_7ffd[3]));
		check_value("motor", 32'(motor), 32'(m_1ffd[3]));
		check_value("paging_locked", 32'(paging_locked), 32'(model_locked()));
	endtask

	task automatic check_access(input logic [15:0] a, input logic rd, input logic wr);
		@(negedge clk_sys);
		addr = a;
		mreq_rd = rd;
		mreq_wr = wr;
		#2;
		check_value("mem_addr", 32'(mem_addr), 32'(expected_addr(a)));
		check_value("mem_rd", 32'(mem_rd), 32'(rd));
		check_value("mem_we", 32'(mem_we), 32'(wr & (m_1ffd[0] | a[15] | a[14])));
	endtask

	task automatic sweep_quarters();
		logic [31:0] r;
		for (int q = 0; q < 4; q++) begin
			r = rand_word();
			check_access({q[1:0], r[13:0]}, 1'b1, 1'b0);
			check_access({q[1:0], r[27:14]}, 1'b0, 1'b1);
		end
	endtask

	// Strobe pulses one cycle after io_wr rises, register follows a cycle later
	task automatic port_write(input logic [15:0] a, input logic [7:0] d);
		logic sel_7ffd;
		logic sel_1ffd;
		logic sel_eff7;
		logic locked;
		@(negedge clk_sys);
		addr = a;
		data = d;
		mreq_rd = 1'b0;
		mreq_wr = 1'b0;
		io_wr = 1'b1;
		@(negedge clk_sys);
		io_wr = 1'b0;
		@(negedge clk_sys);
		sel_7ffd = ~a[15] & ~a[1] & (a[14] | ~m_plus3);
		sel_1ffd = m_plus3 & (a[15:12] == 4'b0001) & ~a[1];
		sel_eff7 = m_p1024 & (a[15:13] == 3'b111) & ~a[12] & ~a[3];
		locked = model_locked();
		if (sel_7ffd && !locked) begin
			m_7ffd = d;
			if (m_p1024 && !m_eff7[2]) begin
				m_ext = {d[5], d[7:6]};
			end
		end
		if (sel_1ffd && !locked) begin
			m_1ffd = d;
		end
		if (sel_eff7) begin
			m_eff7 = d;
		end
		check_state();
	endtask

	task automatic reset_machine(input logic [2:0] code);
		@(negedge clk_sys);
		reset = 1'b1;
		machine = zx_paging_pkg::machine_t'(code);
		io_wr = 1'b0;
		mreq_rd = 1'b0;
		mreq_wr = 1'b0;
		repeat (2) @(negedge clk_sys);
		reset = 1'b0;
		m_7ffd = '0;
		m_1ffd = '0;
		m_eff7 = '0;
		m_ext = '0;
		m_is48 = (code == 3'd3);
		m_plus3 = (code == 3'd4);
		m_p1024 = (code == 3'd1);
		check_state();
	endtask

	task automatic report_test(input string name, input int start_errors);
		if (errors == start_errors) begin
			$display("Test %s: PASS", name);
			passed++;
		end else begin
			$display("Test %s: FAIL (%0d errors)", name, errors - start_errors);
			failed++;
		end
	endtask

	// ==========================================================
	// Test sequence
	// ==========================================================

	initial begin
		int          mark;
		logic [31:0] r;
		reset = 1'b1;
		machine = zx_paging_pkg::MACH_ZX128;
		addr = '0;
		data = '0;
		io_wr = 1'b0;
		mreq_rd = 1'b0;
		mreq_wr = 1'b0;

		// 48K ignores 7FFD entirely
		mark = errors;
		reset_machine(3'd3);
		for (int i = 0; i < 8; i++) begin
			r = rand_word();
			port_write(16'h7ffd, r[7:0]);
			sweep_quarters();
		end
		check_access(16'h0123, 1'b0, 1'b1);
		check_value("mem_addr", 32'(mem_addr), 32'h17c123);
		check_value("mem_we", 32'(mem_we), 32'd0);
		report_test("48K", mark);

		mark = errors;
		reset_machine(3'd0);
		for (int i = 0; i < 12; i++) begin
			r = rand_word();
			port_write(16'h7ffd, r[7:0] & 8'hdf);
			sweep_quarters();
		end
		port_write(16'h7ffd, 8'h23);
		check_value("paging_locked", 32'(paging_locked), 32'd1);
		for (int i = 0; i < 4; i++) begin
			r = rand_word();
			port_write(16'h7ffd, r[7:0]);
			sweep_quarters();
		end
		check_access(16'hc000, 1'b1, 1'b0);
		check_value("mem_addr", 32'(mem_addr), 32'h0c000);
		reset_machine(3'd0);
		check_value("paging_locked", 32'(paging_locked), 32'd0);
		report_test("128K", mark);

		// +3 normal ROM select, then the four all-RAM layouts
		mark = errors;
		reset_machine(3'd4);
		for (int i = 0; i < 4; i++) begin
			r = rand_word();
			port_write(16'h1ffd, {4'h0, r[3], i[1], 2'b00});
			port_write(16'h7ffd, {r[7:6], 1'b0, r[4:0]});
			sweep_quarters();
		end
		for (int cfg = 0; cfg < 4; cfg++) begin
			r = rand_word();
			port_write(16'h1ffd, {4'h0, r[3], cfg[1:0], 1'b1});
			sweep_quarters();
		end
		report_test("+3", mark);

		mark = errors;
		reset_machine(3'd1);
		for (int i = 0; i < 8; i++) begin
			r = rand_word();
			port_write(16'h7ffd, r[7:0]);
			sweep_quarters();
		end
		// D5 set, extends the page and leaves paging unlocked
		port_write(16'h7ffd, 8'he7);
		check_value("paging_locked", 32'(paging_locked), 32'd0);
		check_access(16'hc000, 1'b1, 1'b0);
		check_value("mem_addr", 32'(mem_addr), 32'hfc000);
		port_write(16'heff7, 8'h04);
		r = rand_word();
		port_write(16'h7ffd, r[7:0] & 8'hdf);
		sweep_quarters();
		port_write(16'h7ffd, 8'h20);
		check_value("paging_locked", 32'(paging_locked), 32'd1);
		r = rand_word();
		port_write(16'h7ffd, r[7:0]);
		sweep_quarters();
		report_test("Pentagon 1024", mark);

		// Random machine, memory cycles mixed with port writes
		mark = errors;
		for (int round = 0; round < MIX_ROUNDS; round++) begin
			r = rand_word();
			reset_machine(r[2:0]);
			sweep_quarters();
			for (int op = 0; op < MIX_OPS; op++) begin
				r = rand_word();
				if (r[1:0] == 2'b00) begin
					port_write(pick_port(r[3:2], r[31:16]), r[15:8]);
				end else begin
					check_access(r[31:16], r[2], r[3]);
				end
			end
		end
		report_test("mixed random", mark);

		if (uut.u_assert.failures != 0) begin
			failed++;
		end
		$display("Summary: %0d passed, %0d failed, %0d assertion failures",
			passed, failed, uut.u_assert.failures);
		if (failed == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	// Watchdog, twice the expected run length
	initial begin
		#(TOTAL_CYCLES * CLK_PERIOD * 2);
		$display("Timeout: the run did not finish within %0d cycles", TOTAL_CYCLES * 2);
		$display("Test failures found");
		$finish;
	end

endmodule

//--- zx_port_decode.sv
`timescale 1ns/1ns

module zx_port_decode (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  zx_paging_pkg::machine_t  machine,
	input  zx_paging_pkg::cpu_addr_t addr,
	input  logic                     io_wr,
	output logic                     wr_7ffd,
	output logic                     wr_1ffd,
	output logic                     wr_eff7,
	output logic                     is_48,
	output logic                     is_plus3,
	output logic                     is_p1024
);

	logic io_wr_q;
	logic io_wr_rise;
	logic sel_7ffd;
	logic sel_1ffd;
	logic sel_eff7;

	// ==========================================================
	// Machine type, sampled while reset is held
	// ==========================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			case (machine)
				zx_paging_pkg::MACH_ZX48: begin
					{is_48, is_plus3, is_p1024} <= 3'b100;
				end
				zx_paging_pkg::MACH_PLUS3: begin
					{is_48, is_plus3, is_p1024} <= 3'b010;
				end
				zx_paging_pkg::MACH_P1024: begin
					{is_48, is_plus3, is_p1024} <= 3'b001;
				end
				// 128K, and unknown codes fall back to it
				default: begin
					{is_48, is_plus3, is_p1024} <= 3'b000;
				end
			endcase
		end
	end

	// ==========================================================
	// Port address decode
	// ==========================================================

	// 7FFD is partially decoded, +3 also needs A14
	assign sel_7ffd = ~addr[15] & ~addr[1] & (addr[14] | ~is_plus3);
	assign sel_1ffd = is_plus3 & (addr[15:12] == 4'b0001) & ~addr[1];
	assign sel_eff7 = is_p1024 & (&addr[15:13]) & ~addr[12] & ~addr[3];

	assign io_wr_rise = io_wr & ~io_wr_q;

	// One pulse per write cycle, however long io_wr stays high
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q <= 1'b0;
			wr_7ffd <= 1'b0;
			wr_1ffd <= 1'b0;
			wr_eff7 <= 1'b0;
		end else begin
			io_wr_q <= io_wr;
			wr_7ffd <= io_wr_rise & sel_7ffd;
			wr_1ffd <= io_wr_rise & sel_1ffd;
			wr_eff7 <= io_wr_rise & sel_eff7;
		end
	end

endmodule
